/* hdl/xcvrlb_pkg.sv */
// shared widths, register map addresses and version word
// packed structs for the register bus and lane status
// lane state encoding and the parallel prbs7 step function

package xcvrlb_pkg;

  // ****************************************
  // widths and constants
  // ****************************************

  localparam int LANE_WIDTH = 16;
  localparam int ADDR_WIDTH = 8;
  localparam int DATA_WIDTH = 32;

  localparam logic [DATA_WIDTH-1:0] VERSION = 32'h00010a61;

  // fixed nonzero seed, reloaded while a lane is disabled
  localparam logic [6:0] PRBS_SEED = 7'h7f;

  // register word addresses
  localparam logic [ADDR_WIDTH-1:0] REG_VERSION = 8'h00;
  localparam logic [ADDR_WIDTH-1:0] REG_SCRATCH = 8'h02;
  localparam logic [ADDR_WIDTH-1:0] REG_ENABLE  = 8'h04;
  localparam logic [ADDR_WIDTH-1:0] REG_STATUS  = 8'h05;
  localparam logic [ADDR_WIDTH-1:0] REG_LOCK    = 8'h06;

  // ****************************************
  // types
  // ****************************************

  typedef logic [LANE_WIDTH-1:0] lane_word_t;

  // write request, single-cycle strobe
  typedef struct packed {
    logic                  wreq;
    logic [ADDR_WIDTH-1:0] waddr;
    logic [DATA_WIDTH-1:0] wdata;
  } up_wr_req_t;

  typedef struct packed {
    logic                  rreq;
    logic [ADDR_WIDTH-1:0] raddr;
  } up_rd_req_t;

  // rdata only valid with rack, zero otherwise
  typedef struct packed {
    logic                  rack;
    logic [DATA_WIDTH-1:0] rdata;
  } up_rd_rsp_t;

  // err is a one-cycle strobe
  typedef struct packed {
    logic locked;
    logic err;
  } lane_stat_t;

  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0,
    ST_SYNC   = 2'd1,
    ST_LOCKED = 2'd2
  } lane_state_t;

  // 16 steps of x^7 + x^6 + 1, first bit out lands in the msb
  // the last 7 bits of the word are the state after the steps
  function automatic lane_word_t prbs7_word(input logic [6:0] state);
    logic [6:0] s;
    lane_word_t w;
    int         i;
    s = state;
    w = '0;
    for (i = LANE_WIDTH - 1; i >= 0; i--) begin
      w[i] = s[6] ^ s[5];
      s = {s[5:0], w[i]};
    end
    return w;
  endfunction

endpackage

/* hdl/xcvrlb_good_timer.sv */
// saturating counter of consecutive good words
// done flags that the lock count has been reached

module xcvrlb_good_timer #(
  parameter int LOCK_COUNT = 32
) (
  input  logic up_clk,
  input  logic up_rstn,
  input  logic clear,
  input  logic count,
  output logic done
);

  // wide enough to hold LOCK_COUNT itself
  localparam int CNT_WIDTH = $clog2(LOCK_COUNT + 1);

  logic [CNT_WIDTH-1:0] cnt;

  always_ff @(posedge up_clk) begin
    if (up_rstn == 1'b0) begin
      cnt <= '0;
    end else if (clear) begin
      cnt <= '0;
    end else if (count && !done) begin
      // stops at the lock count
      cnt <= cnt + 1'b1;
    end
  end

  assign done = (cnt == CNT_WIDTH'(LOCK_COUNT));

endmodule

/* hdl/xcvrlb_prbs_gen.sv */
// parallel prbs7 pattern generator
// one 16-bit transmit word per cycle while enabled

module xcvrlb_prbs_gen (
  input  logic                   up_clk,
  input  logic                   up_rstn,
  input  logic                   enable,
  output xcvrlb_pkg::lane_word_t tx_word
);

  logic [6:0]             prbs_state;
  xcvrlb_pkg::lane_word_t word_next;

  // ****************************************
  // 16 unrolled steps per clock
  // ****************************************

  assign word_next = xcvrlb_pkg::prbs7_word(prbs_state);

  always_ff @(posedge up_clk) begin
    if (up_rstn == 1'b0) begin
      prbs_state <= xcvrlb_pkg::PRBS_SEED;
      tx_word <= '0;
    end else if (enable) begin
      tx_word <= word_next;
      // last 7 bits out are the new state
      prbs_state <= word_next[6:0];
    end else begin
      // idle: reload seed, line quiet
      prbs_state <= xcvrlb_pkg::PRBS_SEED;
      tx_word <= '0;
    end
  end

endmodule

/* hdl/xcvrlb_prbs_mon.sv */
// self-synchronizing parallel prbs7 checker
// predicts each received word from the previous one,
// so no seed alignment with the generator is needed

module xcvrlb_prbs_mon (
  input  logic                   up_clk,
  input  logic                   up_rstn,
  input  logic                   enable,
  input  xcvrlb_pkg::lane_word_t rx_word,
  output logic                   word_ok,
  output logic                   word_bad
);

  xcvrlb_pkg::lane_word_t rx_q;
  xcvrlb_pkg::lane_word_t rx_pred;
  logic                   have_word;
  logic                   match;

  // ****************************************
  // prediction and compare
  // ****************************************

  // last 7 received bits recover the sender state
  assign rx_pred = xcvrlb_pkg::prbs7_word(rx_q[6:0]);

  // an all-zero word would predict itself, so reject it outright
  assign match = (rx_word == rx_pred) && (rx_word != '0);

  always_ff @(posedge up_clk) begin
    rx_q <= rx_word;
  end

  always_ff @(posedge up_clk) begin
    if (up_rstn == 1'b0) begin
      have_word <= 1'b0;
      word_ok <= 1'b0;
      word_bad <= 1'b0;
    end else if (enable) begin
      have_word <= 1'b1;
      // first word after enable only primes the predictor
      word_ok <= have_word && match;
      word_bad <= have_word && !match;
    end else begin
      have_word <= 1'b0;
      word_ok <= 1'b0;
      word_bad <= 1'b0;
    end
  end

endmodule

/* hdl/xcvrlb_lane_fsm.sv */
// per-lane control fsm, idle -> sync -> locked
// steers the good-word timer, gates the prbs blocks
// and produces lock and a registered error strobe

module xcvrlb_lane_fsm (
  input  logic                   up_clk,
  input  logic                   up_rstn,
  input  logic                   lane_enable,
  input  logic                   word_ok,
  input  logic                   word_bad,
  input  logic                   timer_done,
  output logic                   timer_clear,
  output logic                   timer_count,
  output logic                   path_enable,
  output xcvrlb_pkg::lane_stat_t stat
);

  xcvrlb_pkg::lane_state_t state;
  xcvrlb_pkg::lane_state_t state_next;
  logic                    err_q;

  // ****************************************
  // state register
  // ****************************************

  always_ff @(posedge up_clk) begin
    if (up_rstn == 1'b0) begin
      state <= xcvrlb_pkg::ST_IDLE;
      err_q <= 1'b0;
    end else begin
      state <= state_next;
      // bad word after lock, flagged in the following cycle
      err_q <= (state == xcvrlb_pkg::ST_LOCKED) && lane_enable && word_bad;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      xcvrlb_pkg::ST_IDLE: begin
        if (lane_enable) begin
          state_next = xcvrlb_pkg::ST_SYNC;
        end
      end
      xcvrlb_pkg::ST_SYNC: begin
        if (!lane_enable) begin
          state_next = xcvrlb_pkg::ST_IDLE;
        end else if (timer_done) begin
          state_next = xcvrlb_pkg::ST_LOCKED;
        end
      end
      xcvrlb_pkg::ST_LOCKED: begin
        // errors after lock are only reported, lock holds
        if (!lane_enable) begin
          state_next = xcvrlb_pkg::ST_IDLE;
        end
      end
      default: state_next = xcvrlb_pkg::ST_IDLE;
    endcase
  end

  // ****************************************
  // outputs
  // ****************************************

  // timer only runs in sync, any bad word restarts the run
  assign timer_clear = (state != xcvrlb_pkg::ST_SYNC) || word_bad;
  assign timer_count = (state == xcvrlb_pkg::ST_SYNC) && word_ok;

  // generator and checker follow the enable directly
  assign path_enable = lane_enable;

  // lock drops at once when the lane is disabled
  always_comb begin
    stat.locked = (state == xcvrlb_pkg::ST_LOCKED) && lane_enable;
    stat.err = err_q;
  end

endmodule

/* hdl/xcvrlb_regmap.sv */
// register file for the loopback tester
// write/read strobe decode, scratch, lane enable,
// sticky per-lane error status and lock readback

module xcvrlb_regmap #(
  parameter int NUM_OF_LANES = 2
) (
  input  logic                                         up_clk,
  input  logic                                         up_rstn,
  input  xcvrlb_pkg::up_wr_req_t                       up_wr,
  output logic                                         up_wack,
  input  xcvrlb_pkg::up_rd_req_t                       up_rd,
  output xcvrlb_pkg::up_rd_rsp_t                       up_rsp,
  output logic                                         lane_enable,
  input  xcvrlb_pkg::lane_stat_t [NUM_OF_LANES-1:0]    lane_stat
);

  logic [xcvrlb_pkg::DATA_WIDTH-1:0] scratch;
  logic [NUM_OF_LANES-1:0]           status;
  logic [NUM_OF_LANES-1:0]           err_vec;
  logic [xcvrlb_pkg::DATA_WIDTH-1:0] status_word;
  logic [xcvrlb_pkg::DATA_WIDTH-1:0] lock_word;
  logic                              wr_scratch;
  logic                              wr_enable;
  logic                              wr_status;

  // ****************************************
  // write decode
  // ****************************************

  assign wr_scratch = up_wr.wreq && (up_wr.waddr == xcvrlb_pkg::REG_SCRATCH);
  assign wr_enable  = up_wr.wreq && (up_wr.waddr == xcvrlb_pkg::REG_ENABLE);
  assign wr_status  = up_wr.wreq && (up_wr.waddr == xcvrlb_pkg::REG_STATUS);

  // lane err strobes and lock bits gathered into words,
  // bits above the lane count stay zero
  always_comb begin
    err_vec = '0;
    status_word = '0;
    lock_word = '0;
    for (int i = 0; i < NUM_OF_LANES; i++) begin
      err_vec[i] = lane_stat[i].err;
      status_word[i] = status[i];
      lock_word[i] = lane_stat[i].locked;
    end
  end

  // host scratch register
  always_ff @(posedge up_clk) begin
    if (wr_scratch) begin
      scratch <= up_wr.wdata;
    end
  end

  always_ff @(posedge up_clk) begin
    if (up_rstn == 1'b0) begin
      up_wack <= 1'b0;
      lane_enable <= 1'b0;
      status <= '0;
    end else begin
      // ack one cycle after the request, known address or not
      up_wack <= up_wr.wreq;
      if (wr_enable) begin
        lane_enable <= up_wr.wdata[0];
      end
      // write one to clear, a new error in the same cycle wins
      if (wr_status) begin
        status <= err_vec | (status & ~up_wr.wdata[NUM_OF_LANES-1:0]);
      end else begin
        status <= err_vec | status;
      end
    end
  end

  // ****************************************
  // readback
  // ****************************************

  always_ff @(posedge up_clk) begin
    if (up_rstn == 1'b0) begin
      up_rsp <= '0;
    end else begin
      up_rsp.rack <= up_rd.rreq;
      if (up_rd.rreq) begin
        case (up_rd.raddr)
          xcvrlb_pkg::REG_VERSION: up_rsp.rdata <= xcvrlb_pkg::VERSION;
          xcvrlb_pkg::REG_SCRATCH: up_rsp.rdata <= scratch;
          xcvrlb_pkg::REG_ENABLE:
            up_rsp.rdata <= {{(xcvrlb_pkg::DATA_WIDTH-1){1'b0}}, lane_enable};
          xcvrlb_pkg::REG_STATUS:  up_rsp.rdata <= status_word;
          xcvrlb_pkg::REG_LOCK:    up_rsp.rdata <= lock_word;
          // unknown addresses read zero
          default:                 up_rsp.rdata <= '0;
        endcase
      end else begin
        // bus is idle low between reads
        up_rsp.rdata <= '0;
      end
    end
  end

endmodule

/* hdl/xcvrlb_top.sv */
// loopback tester top level
// register map plus one generator/checker/fsm/timer per lane

module xcvrlb_top #(
  parameter int NUM_OF_LANES = 2,
  parameter int LOCK_COUNT   = 32
) (
  input  logic                                         up_clk,
  input  logic                                         up_rstn,
  input  xcvrlb_pkg::up_wr_req_t                       up_wr,
  output logic                                         up_wack,
  input  xcvrlb_pkg::up_rd_req_t                       up_rd,
  output xcvrlb_pkg::up_rd_rsp_t                       up_rsp,
  output xcvrlb_pkg::lane_word_t [NUM_OF_LANES-1:0]    tx_data,
  input  xcvrlb_pkg::lane_word_t [NUM_OF_LANES-1:0]    rx_data
);

  logic                                      lane_enable;
  xcvrlb_pkg::lane_stat_t [NUM_OF_LANES-1:0] lane_stat;

  // ****************************************
  // register map
  // ****************************************

  xcvrlb_regmap #(
    .NUM_OF_LANES (NUM_OF_LANES)
  ) u_regmap (
    .up_clk      (up_clk),
    .up_rstn     (up_rstn),
    .up_wr       (up_wr),
    .up_wack     (up_wack),
    .up_rd       (up_rd),
    .up_rsp      (up_rsp),
    .lane_enable (lane_enable),
    .lane_stat   (lane_stat)
  );

  // ****************************************
  // lanes
  // ****************************************

  for (genvar n = 0; n < NUM_OF_LANES; n++) begin : g_lanes
    logic path_enable;
    logic word_ok;
    logic word_bad;
    logic timer_clear;
    logic timer_count;
    logic timer_done;

    // transmit side
    xcvrlb_prbs_gen u_prbs_gen (
      .up_clk  (up_clk),
      .up_rstn (up_rstn),
      .enable  (path_enable),
      .tx_word (tx_data[n])
    );

    // receive side
    xcvrlb_prbs_mon u_prbs_mon (
      .up_clk   (up_clk),
      .up_rstn  (up_rstn),
      .enable   (path_enable),
      .rx_word  (rx_data[n]),
      .word_ok  (word_ok),
      .word_bad (word_bad)
    );

    xcvrlb_lane_fsm u_lane_fsm (
      .up_clk      (up_clk),
      .up_rstn     (up_rstn),
      .lane_enable (lane_enable),
      .word_ok     (word_ok),
      .word_bad    (word_bad),
      .timer_done  (timer_done),
      .timer_clear (timer_clear),
      .timer_count (timer_count),
      .path_enable (path_enable),
      .stat        (lane_stat[n])
    );

    xcvrlb_good_timer #(
      .LOCK_COUNT (LOCK_COUNT)
    ) u_good_timer (
      .up_clk  (up_clk),
      .up_rstn (up_rstn),
      .clear   (timer_clear),
      .count   (timer_count),
      .done    (timer_done)
    );
  end

endmodule

/* tb/xcvrlb_checker.sv */
// bound assertions on the register map
// bus strobe timing, idle read data, lock gated by enable

module xcvrlb_checker #(
  parameter int NUM_OF_LANES = 2
) (
  input logic                                      up_clk,
  input logic                                      up_rstn,
  input xcvrlb_pkg::up_wr_req_t                    up_wr,
  input logic                                      up_wack,
  input xcvrlb_pkg::up_rd_req_t                    up_rd,
  input xcvrlb_pkg::up_rd_rsp_t                    up_rsp,
  input logic                                      lane_enable,
  input xcvrlb_pkg::lane_stat_t [NUM_OF_LANES-1:0] lane_stat
);

  logic [NUM_OF_LANES-1:0] lock_vec;
  int                      assert_fails = 0;

  always_comb begin
    lock_vec = '0;
    for (int i = 0; i < NUM_OF_LANES; i++) begin
      lock_vec[i] = lane_stat[i].locked;
    end
  end

  // ack exactly one cycle after each strobe
  a_wack: assert property (@(posedge up_clk) disable iff (!up_rstn)
    up_wack == $past(up_wr.wreq))
    else begin
      assert_fails++;
      $error("up_wack does not follow wreq by one cycle");
    end

  a_rack: assert property (@(posedge up_clk) disable iff (!up_rstn)
    up_rsp.rack == $past(up_rd.rreq))
    else begin
      assert_fails++;
      $error("rack does not follow rreq by one cycle");
    end

  // read data bus idles at zero
  a_rdata_idle: assert property (@(posedge up_clk) disable iff (!up_rstn)
    !up_rsp.rack |-> up_rsp.rdata == '0)
    else begin
      assert_fails++;
      $error("rdata nonzero while rack is low");
    end

  // lock off while disabled and in the first enabled cycle
  a_lock_gated: assert property (@(posedge up_clk) disable iff (!up_rstn)
    (!lane_enable || !$past(lane_enable)) |-> lock_vec == '0)
    else begin
      assert_fails++;
      $error("lane locked while lane_enable is low or just raised");
    end

endmodule

bind xcvrlb_regmap xcvrlb_checker #(
  .NUM_OF_LANES (NUM_OF_LANES)
) u_checker (
  .up_clk      (up_clk),
  .up_rstn     (up_rstn),
  .up_wr       (up_wr),
  .up_wack     (up_wack),
  .up_rd       (up_rd),
  .up_rsp      (up_rsp),
  .lane_enable (lane_enable),
  .lane_stat   (lane_stat)
);

/* tb/xcvrlb_tb.sv */
// loopback testbench for the transceiver tester
// closes tx onto rx with bit-error injection,
// directed register, pattern, lock and status tests

module xcvrlb_tb;

  localparam int NUM_OF_LANES   = 2;
  localparam int LOCK_COUNT     = 32;
  localparam int TIMEOUT_CYCLES = 2000;
  // lock bound plus one cycle of read latency
  localparam int LOCK_LIMIT = LOCK_COUNT + 4 + 1;
  localparam logic [31:0] LANE_MASK = 32'((1 << NUM_OF_LANES) - 1);

  logic                                      up_clk;
  logic                                      up_rstn;
  xcvrlb_pkg::up_wr_req_t                    up_wr;
  logic                                      up_wack;
  xcvrlb_pkg::up_rd_req_t                    up_rd;
  xcvrlb_pkg::up_rd_rsp_t                    up_rsp;
  xcvrlb_pkg::lane_word_t [NUM_OF_LANES-1:0] tx_data;
  xcvrlb_pkg::lane_word_t [NUM_OF_LANES-1:0] rx_data;
  xcvrlb_pkg::lane_word_t [NUM_OF_LANES-1:0] err_mask;
  logic [15:0]                               lfsr_state;
  int                                        cycle_cnt = 0;
  int                                        mismatch_cnt = 0;
  int                                        other_cnt = 0;
  int                                        total_errs;

  // word-level loopback, mask flips bits for one cycle
  assign rx_data = tx_data ^ err_mask;

  xcvrlb_top #(
    .NUM_OF_LANES (NUM_OF_LANES),
    .LOCK_COUNT   (LOCK_COUNT)
  ) u_xcvrlb_top (
    .up_clk  (up_clk),
    .up_rstn (up_rstn),
    .up_wr   (up_wr),
    .up_wack (up_wack),
    .up_rd   (up_rd),
    .up_rsp  (up_rsp),
    .tx_data (tx_data),
    .rx_data (rx_data)
  );

  initial begin
    up_clk = 1'b0;
    forever #50 up_clk = ~up_clk;
  end

  // cycle count, also the run limit
  always @(posedge up_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, tests did not complete", cycle_cnt);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // ****************************************
  // helpers
  // ****************************************

  // fibonacci lfsr x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [31:0] rand_bits(input int nbits);
    logic [31:0] r;
    logic        fb;
    int          i;
    r = '0;
    for (i = 0; i < nbits; i++) begin
      fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  // b[n] = b[n-7] ^ b[n-6], oldest bit at the msb
  function automatic xcvrlb_pkg::lane_word_t expected_next(
    input xcvrlb_pkg::lane_word_t prev);
    logic [31:0] seq;
    int          k;
    seq = {prev, 16'h0000};
    for (k = 15; k >= 0; k--) begin
      seq[k] = seq[k+7] ^ seq[k+6];
    end
    return seq[15:0];
  endfunction

  task automatic check_word(input string name,
                            input logic [xcvrlb_pkg::DATA_WIDTH-1:0] got,
                            input logic [xcvrlb_pkg::DATA_WIDTH-1:0] exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_lane(input string name, input xcvrlb_pkg::lane_word_t got,
                            input xcvrlb_pkg::lane_word_t exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge up_clk);
      #10;
    end
  endtask

  // one write strobe, then wait for the ack
  task automatic write_reg(input logic [xcvrlb_pkg::ADDR_WIDTH-1:0] addr,
                           input logic [xcvrlb_pkg::DATA_WIDTH-1:0] data);
    int waited;
    waited = 0;
    up_wr.wreq = 1'b1;
    up_wr.waddr = addr;
    up_wr.wdata = data;
    @(posedge up_clk);
    #10;
    up_wr.wreq = 1'b0;
    while (!up_wack && waited < 4) begin
      @(posedge up_clk);
      #10;
      waited++;
    end
    if (!up_wack) begin
      other_cnt++;
      $display("no write acknowledge for address 0x%h", addr);
    end
  endtask

  // one read strobe, data taken with rack
  task automatic read_reg(input logic [xcvrlb_pkg::ADDR_WIDTH-1:0] addr,
                          output logic [xcvrlb_pkg::DATA_WIDTH-1:0] data);
    int waited;
    waited = 0;
    up_rd.rreq = 1'b1;
    up_rd.raddr = addr;
    @(posedge up_clk);
    #10;
    up_rd.rreq = 1'b0;
    while (!up_rsp.rack && waited < 4) begin
      @(posedge up_clk);
      #10;
      waited++;
    end
    data = up_rsp.rdata;
    if (!up_rsp.rack) begin
      other_cnt++;
      $display("no read acknowledge for address 0x%h", addr);
    end
  endtask

  task automatic inject_bit_error(input int lane, input logic [3:0] pos);
    err_mask[lane][pos] = 1'b1;
    @(posedge up_clk);
    #10;
    err_mask = '0;
  endtask

  // ****************************************
  // directed tests
  // ****************************************

  task automatic test_registers();
    logic [31:0] rd;
    logic [31:0] wdata;
    read_reg(xcvrlb_pkg::REG_VERSION, rd);
    check_word("REG_VERSION", rd, xcvrlb_pkg::VERSION);
    wdata = rand_bits(32);
    write_reg(xcvrlb_pkg::REG_SCRATCH, wdata);
    read_reg(xcvrlb_pkg::REG_SCRATCH, rd);
    check_word("REG_SCRATCH", rd, wdata);
    // unmapped reads zero
    read_reg(8'h03, rd);
    check_word("unmapped 0x03", rd, 32'h0);
  endtask

  task automatic test_prbs_pattern();
    xcvrlb_pkg::lane_word_t prev [NUM_OF_LANES];
    logic [31:0]            rd;
    int                     n;
    for (n = 0; n < NUM_OF_LANES; n++) begin
      check_lane($sformatf("tx_data[%0d]", n), tx_data[n], '0);
    end
    write_reg(xcvrlb_pkg::REG_ENABLE, 32'h1);
    idle_cycles(1);
    for (n = 0; n < NUM_OF_LANES; n++) begin
      prev[n] = tx_data[n];
      if (prev[n] == '0) begin
        other_cnt++;
        $display("tx_data[%0d] stayed zero after enable", n);
      end
    end
    // each word is the previous one advanced 16 steps
    repeat (8) begin
      idle_cycles(1);
      for (n = 0; n < NUM_OF_LANES; n++) begin
        check_lane($sformatf("tx_data[%0d]", n), tx_data[n], expected_next(prev[n]));
        prev[n] = tx_data[n];
      end
    end
    read_reg(xcvrlb_pkg::REG_ENABLE, rd);
    check_word("REG_ENABLE", rd, 32'h1);
  endtask

  task automatic test_lock();
    logic [31:0] rd;
    int          start;
    write_reg(xcvrlb_pkg::REG_ENABLE, 32'h0);
    idle_cycles(2);
    write_reg(xcvrlb_pkg::REG_ENABLE, 32'h1);
    start = cycle_cnt;
    rd = '0;
    while (rd != LANE_MASK && (cycle_cnt - start) < LOCK_LIMIT) begin
      read_reg(xcvrlb_pkg::REG_LOCK, rd);
    end
    if (rd != LANE_MASK) begin
      other_cnt++;
      $display("lanes not locked within %0d cycles of enable, lock 0x%h", LOCK_LIMIT, rd);
    end
    read_reg(xcvrlb_pkg::REG_STATUS, rd);
    check_word("REG_STATUS", rd, 32'h0);
  endtask

  task automatic test_error_inject();
    logic [31:0] rd;
    logic [3:0]  pos;
    pos = 4'(rand_bits(4));
    inject_bit_error(1, pos);
    // strobe, err register, sticky bit, plus a second bad word
    idle_cycles(4);
    read_reg(xcvrlb_pkg::REG_STATUS, rd);
    check_word("REG_STATUS", rd, 32'h2);
    read_reg(xcvrlb_pkg::REG_LOCK, rd);
    check_word("REG_LOCK", rd, LANE_MASK);
  endtask

  task automatic test_clear_disable();
    logic [31:0] rd;
    int          n;
    write_reg(xcvrlb_pkg::REG_STATUS, 32'h2);
    read_reg(xcvrlb_pkg::REG_STATUS, rd);
    check_word("REG_STATUS", rd, 32'h0);
    write_reg(xcvrlb_pkg::REG_ENABLE, 32'h0);
    read_reg(xcvrlb_pkg::REG_LOCK, rd);
    check_word("REG_LOCK", rd, 32'h0);
    for (n = 0; n < NUM_OF_LANES; n++) begin
      check_lane($sformatf("tx_data[%0d]", n), tx_data[n], '0);
    end
  endtask

  initial begin
    up_rstn = 1'b0;
    up_wr = '0;
    up_rd = '0;
    err_mask = '0;
    lfsr_state = 16'd41;
    repeat (10) @(posedge up_clk);
    #10;
    up_rstn = 1'b1;
    test_registers();
    test_prbs_pattern();
    test_lock();
    test_error_inject();
    test_clear_disable();
    total_errs = mismatch_cnt + other_cnt + u_xcvrlb_top.u_regmap.u_checker.assert_fails;
    $display("errors: %0d mismatches, %0d other, %0d assertion failures",
             mismatch_cnt, other_cnt, u_xcvrlb_top.u_regmap.u_checker.assert_fails);
    if (total_errs == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* all.f */
hdl/xcvrlb_pkg.sv
hdl/xcvrlb_good_timer.sv
hdl/xcvrlb_prbs_gen.sv
hdl/xcvrlb_prbs_mon.sv
hdl/xcvrlb_lane_fsm.sv
hdl/xcvrlb_regmap.sv
hdl/xcvrlb_top.sv
tb/xcvrlb_checker.sv
tb/xcvrlb_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the loopback testbench with verilator
set -e

verilator --binary --timing --assert -Wno-fatal \
  --top-module xcvrlb_tb -f all.f -o xcvrlb_sim

./obj_dir/xcvrlb_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
